// ==== rtl/vision_pkg.sv ====
//====================================================================
// Vision package
// Pixel widths, stream constants and shared types of the camera
// video path
//====================================================================
package vision_pkg;

  //==================================================================
  // Data widths
  //==================================================================
  typedef logic [11:0] raw_pix_t;  // Raw Bayer sample from the sensor
  typedef logic [11:0] chan_t;     // One RGB colour channel
  typedef logic [7:0]  byte_pix_t; // Gray, threshold or mask byte
  typedef logic [11:0] coord_t;    // Column or row index
  typedef logic [31:0] count_t;    // Frame counter and rate value

  //==================================================================
  // Stream constants
  //==================================================================
  // Widest raw line the Bayer line buffer can hold
  localparam int MAX_LINE_W = 2048;
  localparam int LINE_AW    = $clog2(MAX_LINE_W); // Line buffer address bits

  // Frame ends to skip after reset before the stream opens
  localparam int SYNC_FRAMES = 2;

  // Mask byte values
  localparam byte_pix_t MASK_ON  = 8'd255;
  localparam byte_pix_t MASK_OFF = 8'd0;

  // One second of CLOCK_50
  localparam int unsigned DEF_RATE_WINDOW = 50_000_000;

  //==================================================================
  // FSM encodings
  //==================================================================
  // Frame synchronizer states
  typedef enum logic [1:0] {
    SYNC_WAIT, // Counting frame ends
    SYNC_ARM,  // Count reached, waiting for blanking
    SYNC_OPEN  // Pixels pass until reset
  } sync_state_t;

endpackage

// ==== rtl/camera_capture.sv ====
//====================================================================
// Camera capture
// Samples the sensor pins, admits whole frames while capture is
// enabled and tracks column, row and captured frame count
//====================================================================
module camera_capture import vision_pkg::*; (
  input  logic     CLOCK_50,
  input  logic     rst,
  input  raw_pix_t cam_data,
  input  logic     cam_fval,
  input  logic     cam_lval,
  input  logic     capture_en,
  output raw_pix_t raw_data,
  output logic     raw_valid,
  output coord_t   col,
  output coord_t   row,
  output logic     frame_valid,
  output count_t   frame_count
);

  raw_pix_t data_q;      // Pin register stage
  logic     fval_q;
  logic     lval_q;
  logic     fval_d;      // Previous registered frame-valid
  logic     lval_d;      // Previous registered line-valid
  logic     cap_active;  // Current frame is being captured
  logic     cap_now;
  logic     fval_rise;
  coord_t   x_cnt;       // Column of the next sample
  coord_t   y_cnt;       // Row of the current line

  //==================================================================
  // Pin registers
  //==================================================================
  always_ff @(posedge CLOCK_50) begin
    data_q <= cam_data; // Payload, no reset
    if (rst) begin
      fval_q <= 1'b0;
      lval_q <= 1'b0;
      fval_d <= 1'b0;
      lval_d <= 1'b0;
    end else begin
      fval_q <= cam_fval;
      lval_q <= cam_lval;
      fval_d <= fval_q;
      lval_d <= lval_q;
    end
  end

  // Capture decision taken only on the frame start
  assign fval_rise = fval_q & ~fval_d;
  assign cap_now   = fval_q & (fval_rise ? capture_en : cap_active);

  //==================================================================
  // Gated stream and counters
  //==================================================================
  always_ff @(posedge CLOCK_50) begin
    raw_data <= data_q;
    if (rst) begin
      cap_active  <= 1'b0;
      raw_valid   <= 1'b0;
      frame_valid <= 1'b0;
      frame_count <= '0;
      x_cnt       <= '0;
      y_cnt       <= '0;
      col         <= '0;
      row         <= '0;
    end else begin
      cap_active  <= cap_now;
      frame_valid <= cap_now;
      raw_valid   <= cap_now & lval_q;
      if (cap_active && !cap_now)
        frame_count <= frame_count + 1'b1; // Captured frame ended
      if (!cap_now) begin              // Outside a captured frame
        x_cnt <= '0;
        y_cnt <= '0;
      end else if (lval_q) begin       // Active sample
        col   <= x_cnt;
        row   <= y_cnt;
        x_cnt <= x_cnt + 1'b1;
      end else if (lval_d) begin       // Line just ended
        x_cnt <= '0;
        y_cnt <= y_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== rtl/bayer_to_rgb.sv ====
//====================================================================
// Bayer to RGB
// Folds each 2x2 Bayer cell into one RGB pixel using a single line
// buffer for the even rows
//====================================================================
module bayer_to_rgb import vision_pkg::*; (
  input  logic     CLOCK_50,
  input  logic     rst,
  input  raw_pix_t raw_data,
  input  logic     raw_valid,
  input  coord_t   col,
  input  coord_t   row,
  output chan_t    red,
  output chan_t    green,
  output chan_t    blue,
  output logic     rgb_valid
);

  // Cell layout
  //   even row   G1 R  G1 R ...
  //   odd row    B  G2 B  G2 ...

  raw_pix_t               line_buf [0:MAX_LINE_W-1]; // Even row storage
  logic [LINE_AW-1:0]     wr_addr;
  logic [LINE_AW-1:0]     prev_addr;
  raw_pix_t               above_r;   // Red from row above
  raw_pix_t               above_g;   // Green 1 from row above
  raw_pix_t               prev_pix;  // Last sample of current row
  logic [12:0]            g_sum;
  logic                   cell_done;

  assign wr_addr   = col[LINE_AW-1:0];
  assign prev_addr = wr_addr - 1'b1;

  // Odd row, odd column closes a cell
  assign cell_done = raw_valid & row[0] & col[0];

  //==================================================================
  // Line buffer
  //==================================================================
  always_ff @(posedge CLOCK_50) begin
    if (raw_valid && !row[0])
      line_buf[wr_addr] <= raw_data; // Whole even row, G1 and R
  end

  assign above_r = line_buf[wr_addr];
  assign above_g = line_buf[prev_addr];

  // Previous sample, gives blue on the closing sample
  always_ff @(posedge CLOCK_50) begin
    if (raw_valid)
      prev_pix <= raw_data;
  end

  // Average of G1 and G2, one extra bit for the carry
  assign g_sum = {1'b0, above_g} + {1'b0, raw_data};

  //==================================================================
  // RGB output register
  //==================================================================
  always_ff @(posedge CLOCK_50) begin
    if (cell_done) begin
      red   <= above_r;
      green <= g_sum[12:1];
      blue  <= prev_pix;
    end
  end

  always_ff @(posedge CLOCK_50) begin
    if (rst)
      rgb_valid <= 1'b0;
    else
      rgb_valid <= cell_done; // One pixel per 2x2 cell
  end

endmodule

// ==== rtl/frame_sync.sv ====
//====================================================================
// Frame synchronizer
// Holds the RGB stream off after reset until whole frames can be
// passed from their first pixel
//====================================================================
module frame_sync import vision_pkg::*; (
  input  logic  CLOCK_50,
  input  logic  rst,
  input  chan_t in_red,
  input  chan_t in_green,
  input  chan_t in_blue,
  input  logic  in_valid,
  input  logic  frame_valid,
  output chan_t out_red,
  output chan_t out_green,
  output chan_t out_blue,
  output logic  out_valid
);

  localparam int CW = $clog2(SYNC_FRAMES + 1);
  localparam logic [CW-1:0] LAST_END = CW'(SYNC_FRAMES - 1);

  sync_state_t   state;
  logic [CW-1:0] end_cnt;   // Frame ends seen so far
  logic          fv_d;
  logic          frame_end;

  assign frame_end = fv_d & ~frame_valid;

  // Gate FSM, stays open once opened
  always_ff @(posedge CLOCK_50) begin
    if (rst) begin
      state   <= SYNC_WAIT;
      end_cnt <= '0;
      fv_d    <= 1'b0;
    end else begin
      fv_d <= frame_valid;
      case (state)
        SYNC_WAIT:
          if (frame_end) begin
            if (end_cnt == LAST_END)
              state <= SYNC_ARM;
            else
              end_cnt <= end_cnt + 1'b1;
          end
        SYNC_ARM:
          if (!frame_valid)
            state <= SYNC_OPEN; // Only in blanking
        default:
          state <= SYNC_OPEN;
      endcase
    end
  end

  // Pixel register
  always_ff @(posedge CLOCK_50) begin
    out_red   <= in_red;
    out_green <= in_green;
    out_blue  <= in_blue;
    if (rst)
      out_valid <= 1'b0;
    else
      out_valid <= in_valid & (state == SYNC_OPEN);
  end

endmodule

// ==== rtl/pixel_classifier.sv ====
//====================================================================
// Pixel classifier
// Two-stage pipeline producing a gray byte and a red marker mask
// from brightness and chroma windows
//====================================================================
module pixel_classifier import vision_pkg::*; (
  input  logic      CLOCK_50,
  input  logic      rst,
  input  chan_t     red,
  input  chan_t     green,
  input  chan_t     blue,
  input  logic      in_valid,
  input  byte_pix_t bri_thres_l,
  input  byte_pix_t bri_thres_h,
  input  byte_pix_t chroma_thres_l,
  input  byte_pix_t chroma_thres_h,
  output byte_pix_t gray,
  output byte_pix_t bin,
  output logic      out_valid
);

  byte_pix_t   r8;
  byte_pix_t   g8;
  byte_pix_t   b8;
  byte_pix_t   max_c;
  byte_pix_t   min_c;
  logic [13:0] gray_sum;   // R + 2G + B, full width
  logic [13:0] gray_sum_q;
  byte_pix_t   max_q;
  byte_pix_t   min_q;
  logic        red_top_q;  // Red is the largest component
  logic        v1;
  byte_pix_t   chroma;
  logic        hit;

  //==================================================================
  // Stage one
  //==================================================================
  assign r8 = red[11:4];   // Upper byte of each channel
  assign g8 = green[11:4];
  assign b8 = blue[11:4];

  assign max_c = (r8 >= g8) ? ((r8 >= b8) ? r8 : b8) : ((g8 >= b8) ? g8 : b8);
  assign min_c = (r8 <= g8) ? ((r8 <= b8) ? r8 : b8) : ((g8 <= b8) ? g8 : b8);

  assign gray_sum = {2'b00, red} + {1'b0, green, 1'b0} + {2'b00, blue};

  always_ff @(posedge CLOCK_50) begin
    gray_sum_q <= gray_sum;
    max_q      <= max_c;
    min_q      <= min_c;
    red_top_q  <= (r8 >= g8) && (r8 >= b8); // Ties count as red
  end

  //==================================================================
  // Stage two
  //==================================================================
  assign chroma = max_q - min_q; // Never wraps

  assign hit = red_top_q &&
               (max_q  >= bri_thres_l)    && (max_q  <= bri_thres_h) &&
               (chroma >= chroma_thres_l) && (chroma <= chroma_thres_h);

  always_ff @(posedge CLOCK_50) begin
    gray <= gray_sum_q[13:6]; // Divide by 4, keep upper byte
    bin  <= hit ? MASK_ON : MASK_OFF;
  end

  // Valid pipeline
  always_ff @(posedge CLOCK_50) begin
    if (rst) begin
      v1        <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      v1        <= in_valid;
      out_valid <= v1;
    end
  end

endmodule

// ==== rtl/rate_meter.sv ====
//====================================================================
// Rate meter
// Frames captured per window and a heartbeat LED
//====================================================================
module rate_meter import vision_pkg::*; #(
  parameter int unsigned RATE_WINDOW = DEF_RATE_WINDOW
) (
  input  logic   CLOCK_50,
  input  logic   rst,
  input  count_t frame_count,
  output count_t rate,
  output logic   pulse_led
);

  localparam count_t WIN_LAST = count_t'(RATE_WINDOW - 1);

  count_t win_cnt;  // Cycles into current window
  count_t snap;     // Frame count at last wrap

  always_ff @(posedge CLOCK_50) begin
    if (rst) begin
      win_cnt   <= '0;
      snap      <= '0;
      rate      <= '0;
      pulse_led <= 1'b0;
    end else if (win_cnt == WIN_LAST) begin
      win_cnt   <= '0;
      rate      <= frame_count - snap; // Frames in this window
      snap      <= frame_count;
      pulse_led <= ~pulse_led;         // Heartbeat
    end else begin
      win_cnt <= win_cnt + 1'b1;
    end
  end

endmodule

// ==== rtl/uvispace_top.sv ====
//====================================================================
// Uvispace video top
// Camera capture, Bayer conversion, frame sync, classifier and
// frame rate meter on CLOCK_50
//====================================================================
module uvispace_top import vision_pkg::*; #(
  parameter int unsigned RATE_WINDOW = DEF_RATE_WINDOW // 1 s at 50 MHz
) (
  input  logic      CLOCK_50,
  input  logic      rst,
  input  raw_pix_t  cam_data,
  input  logic      cam_fval,
  input  logic      cam_lval,
  input  logic      capture_en,
  input  byte_pix_t bri_thres_l,
  input  byte_pix_t bri_thres_h,
  input  byte_pix_t chroma_thres_l,
  input  byte_pix_t chroma_thres_h,
  output chan_t     sync_red,
  output chan_t     sync_green,
  output chan_t     sync_blue,
  output logic      sync_valid,
  output byte_pix_t gray,
  output logic      gray_valid,
  output byte_pix_t bin,
  output logic      bin_valid,
  output count_t    rate,
  output logic      pulse_led
);

  raw_pix_t raw_data;     // Capture to Bayer
  logic     raw_valid;
  coord_t   col;
  coord_t   row;
  logic     frame_valid;  // Gated frame level
  count_t   frame_count;
  chan_t    rgb_red;      // Bayer to sync
  chan_t    rgb_green;
  chan_t    rgb_blue;
  logic     rgb_valid;

  //==================================================================
  // Video chain
  //==================================================================
  camera_capture u_capture (
    .CLOCK_50, .rst, .cam_data, .cam_fval, .cam_lval, .capture_en,
    .raw_data, .raw_valid, .col, .row, .frame_valid, .frame_count
  );

  bayer_to_rgb u_bayer (
    .CLOCK_50, .rst, .raw_data, .raw_valid, .col, .row,
    .red(rgb_red), .green(rgb_green), .blue(rgb_blue), .rgb_valid
  );

  frame_sync u_sync (
    .CLOCK_50, .rst,
    .in_red(rgb_red), .in_green(rgb_green), .in_blue(rgb_blue),
    .in_valid(rgb_valid), .frame_valid,
    .out_red(sync_red), .out_green(sync_green), .out_blue(sync_blue),
    .out_valid(sync_valid)
  );

  pixel_classifier u_classify (
    .CLOCK_50, .rst,
    .red(sync_red), .green(sync_green), .blue(sync_blue), .in_valid(sync_valid),
    .bri_thres_l, .bri_thres_h, .chroma_thres_l, .chroma_thres_h,
    .gray, .bin, .out_valid(gray_valid)
  );

  assign bin_valid = gray_valid; // Same strobe for both exports

  //==================================================================
  // Frame rate
  //==================================================================
  rate_meter #(.RATE_WINDOW(RATE_WINDOW)) u_rate (
    .CLOCK_50, .rst, .frame_count, .rate, .pulse_led
  );

endmodule

// ==== test/uvispace_assertions.sv ====
//====================================================================
// Uvispace output assertions
// Reset quiet, mask values and valid alignment on the video top
//====================================================================
module uvispace_assertions import vision_pkg::*; (
  input logic      CLOCK_50,
  input logic      rst,
  input logic      sync_valid,
  input logic      gray_valid,
  input logic      bin_valid,
  input byte_pix_t bin
);

  // Valids held low through reset
  a_reset_quiet: assert property (@(posedge CLOCK_50)
    rst && $past(rst) |-> !sync_valid && !gray_valid && !bin_valid)
    else $error("Valid output high during reset");

  a_mask_values: assert property (@(posedge CLOCK_50) disable iff (rst)
    bin_valid |-> (bin == MASK_ON || bin == MASK_OFF))
    else $error("Mask byte neither 0 nor 255");

  a_same_strobe: assert property (@(posedge CLOCK_50) disable iff (rst)
    gray_valid == bin_valid)
    else $error("gray_valid and bin_valid differ");

  // Classifier is a two stage pipeline
  a_gray_latency: assert property (@(posedge CLOCK_50) disable iff (rst)
    gray_valid == $past(sync_valid, 2))
    else $error("gray_valid does not trail sync_valid by 2 cycles");

endmodule

bind uvispace_top uvispace_assertions u_assertions (
  .CLOCK_50,
  .rst,
  .sync_valid,
  .gray_valid,
  .bin_valid,
  .bin
);

// ==== test/tb_uvispace_top.sv ====
//====================================================================
// Uvispace video testbench
// Random Bayer frames into the video top, checked in order against
// a Bayer, gray and marker model, plus frame rate and LED checks
//====================================================================
module tb_uvispace_top import vision_pkg::*; ();

  localparam int FRAME_W     = 8;   // Raw samples per line
  localparam int FRAME_H     = 6;   // Raw lines per frame
  localparam int LINE_BLANK  = 3;
  localparam int FRAME_BLANK = 10;
  localparam int FRAME_CYC   = FRAME_H * (FRAME_W + LINE_BLANK) + FRAME_BLANK;
  localparam int RATE_WIN    = 4000;
  localparam int CLK_PERIOD  = 10;
  localparam int RATE_FRAMES = 115; // Spans two LED toggles
  localparam int TOTAL_FRAMES = 3 + 4 + 5 + 4 + RATE_FRAMES;
  localparam int TIMEOUT     = (TOTAL_FRAMES * FRAME_CYC + 500) * CLK_PERIOD;

  logic      CLOCK_50;
  logic      rst;
  raw_pix_t  cam_data;
  logic      cam_fval, cam_lval, capture_en;
  byte_pix_t bri_thres_l, bri_thres_h, chroma_thres_l, chroma_thres_h;
  chan_t     sync_red, sync_green, sync_blue;
  logic      sync_valid, gray_valid, bin_valid, pulse_led;
  byte_pix_t gray, bin;
  count_t    rate;

  logic [31:0] lfsr = 32'h4ded;       // Stimulus LFSR state
  raw_pix_t    frm [0:FRAME_H-1][0:FRAME_W-1];
  logic [35:0] exp_rgb [$];           // {r, g, b} in arrival order
  logic [15:0] exp_gb [$];            // {gray, mask}
  logic [35:0] e_rgb;
  logic [15:0] e_gb;
  int          errors, tests_run, tests_failed, n_sync, n_captured, err0, n0;
  time         t_first, t_second;

  uvispace_top #(.RATE_WINDOW(RATE_WIN)) DUT (.*);

  initial begin
    CLOCK_50 = 1'b0;
    forever #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  //==================================================================
  // Reference model
  //==================================================================
  function automatic logic [15:0] classify(input chan_t r, input chan_t g, input chan_t b);
    int        s, r8, g8, b8, mx, mn;
    logic      on;
    byte_pix_t gy;
    s  = r + 2 * g + b;
    gy = (s / 4) / 16;           // Upper byte of the 12 bit average
    r8 = r / 16;
    g8 = g / 16;
    b8 = b / 16;
    mx = (r8 > g8) ? r8 : g8;
    mx = (b8 > mx) ? b8 : mx;
    mn = (r8 < g8) ? r8 : g8;
    mn = (b8 < mn) ? b8 : mn;
    on = (r8 >= g8) && (r8 >= b8) && (mx >= bri_thres_l) && (mx <= bri_thres_h) &&
         (mx - mn >= chroma_thres_l) && (mx - mn <= chroma_thres_h);
    return {gy, on ? MASK_ON : MASK_OFF};
  endfunction

  // One RGB pixel per odd row, odd column
  task automatic push_expected();
    chan_t       r, g, b;
    logic [12:0] gs;
    for (int y = 1; y < FRAME_H; y += 2) begin
      for (int x = 1; x < FRAME_W; x += 2) begin
        r  = frm[y-1][x];        // Red above
        b  = frm[y][x-1];        // Blue to the left
        gs = frm[y-1][x-1] + frm[y][x];
        g  = gs[12:1];
        exp_rgb.push_back({r, g, b});
        exp_gb.push_back(classify(r, g, b));
      end
    end
  endtask

  // One 8x6 frame, capture_en set at frame start and maybe dropped
  task automatic send_frame(input logic cap, input int drop_row);
    for (int y = 0; y < FRAME_H; y++)
      for (int x = 0; x < FRAME_W; x++)
        frm[y][x] = rand_bits(12);
    if (cap) begin
      if (n_captured >= SYNC_FRAMES) push_expected(); // Past the sync gate
      n_captured++;
    end
    for (int y = 0; y < FRAME_H; y++) begin
      for (int x = 0; x < FRAME_W + LINE_BLANK; x++) begin
        @(posedge CLOCK_50);
        #1;
        if (y == 0 && x == 0) capture_en = cap;
        if (y == drop_row && x == 0) capture_en = 1'b0;
        cam_fval = 1'b1;
        cam_lval = (x < FRAME_W);
        if (x < FRAME_W) cam_data = frm[y][x];
        else cam_data = '0;
      end
    end
    repeat (FRAME_BLANK) begin
      @(posedge CLOCK_50);
      #1;
      cam_fval = 1'b0;
      cam_lval = 1'b0;
    end
  endtask

  task automatic finish_test(input string name);
    int k;
    k = 0;
    while ((exp_rgb.size() != 0 || exp_gb.size() != 0) && k < 100) begin
      @(posedge CLOCK_50);
      k++;
    end
    assert (exp_rgb.size() == 0 && exp_gb.size() == 0) else begin
      $display("Outputs missing in %s: %0d rgb, %0d gray", name, exp_rgb.size(),
               exp_gb.size());
      errors++;
    end
    tests_run++;
    if (errors != err0) tests_failed++;
    $display("%s: %s", name, (errors == err0) ? "pass" : "fail");
  endtask

  task automatic wait_toggle(output time t);
    logic led0;
    led0 = pulse_led;
    while (pulse_led == led0) @(negedge CLOCK_50);
    t = $time;
  endtask

  task automatic random_thresholds();
    bri_thres_l    = rand_bits(7);
    bri_thres_h    = bri_thres_l + rand_bits(7); // Never below the low bound
    chroma_thres_l = rand_bits(7);
    chroma_thres_h = chroma_thres_l + rand_bits(7);
  endtask

  //==================================================================
  // Output monitor, in order against the model queues
  //==================================================================
  always @(negedge CLOCK_50) begin
    if (!rst && sync_valid) begin
      n_sync++;
      if (exp_rgb.size() == 0) begin
        $display("Unexpected sync pixel at time %0t", $time);
        errors++;
      end else begin
        e_rgb = exp_rgb.pop_front();
        assert ({sync_red, sync_green, sync_blue} == e_rgb) else begin
          $display("ERR %0t: sync rgb %h, expected %h", $time,
                   {sync_red, sync_green, sync_blue}, e_rgb);
          errors++;
        end
      end
    end
    if (!rst && (gray_valid || bin_valid)) begin
      if (exp_gb.size() == 0) begin
        $display("Unexpected gray or mask pixel at time %0t", $time);
        errors++;
      end else begin
        e_gb = exp_gb.pop_front();
        assert (gray_valid && bin_valid && {gray, bin} == e_gb) else begin
          $display("ERR %0t: gray/bin %h/%h valid %b/%b, expected %h/%h", $time,
                   gray, bin, gray_valid, bin_valid, e_gb[15:8], e_gb[7:0]);
          errors++;
        end
      end
    end
  end

  // Watchdog
  initial begin
    #(TIMEOUT);
    $display("Timeout: the run did not finish in the expected time");
    $display("TESTS FAILED");
    $finish;
  end

  //==================================================================
  // Test sequence
  //==================================================================
  initial begin
    rst = 1'b1;
    cam_data = '0;
    cam_fval = 1'b0;
    cam_lval = 1'b0;
    capture_en = 1'b0;
    bri_thres_l = '0;
    bri_thres_h = '0;
    chroma_thres_l = '0;
    chroma_thres_h = '0;
    repeat (10) @(posedge CLOCK_50);
    #1 rst = 1'b0;

    // Startup gate
    err0 = errors;
    random_thresholds();
    assert (rate == 0 && !pulse_led && !sync_valid && !gray_valid) else begin
      $display("ERR %0t: outputs not idle after reset", $time);
      errors++;
    end
    n0 = n_sync;
    repeat (SYNC_FRAMES) send_frame(1'b1, -1);
    assert (n_sync == n0) else begin
      $display("ERR %0t: %0d pixels before sync", $time, n_sync - n0);
      errors++;
    end
    send_frame(1'b1, -1);
    assert (n_sync - n0 == 12) else begin
      $display("ERR %0t: first frame gave %0d pixels, expected 12", $time, n_sync - n0);
      errors++;
    end
    finish_test("startup sync");

    err0 = errors;
    repeat (4) send_frame(1'b1, -1);
    finish_test("bayer rgb");

    // Random windows, then wide open windows
    err0 = errors;
    repeat (4) begin
      random_thresholds();
      send_frame(1'b1, -1);
    end
    bri_thres_l = 8'd0;
    bri_thres_h = 8'd255;
    chroma_thres_l = 8'd0;
    chroma_thres_h = 8'd255;
    send_frame(1'b1, -1);
    finish_test("classifier");

    // Capture enable dropped in mid frame
    err0 = errors;
    n0 = n_sync;
    send_frame(1'b1, 3);
    repeat (2) send_frame(1'b0, -1);
    send_frame(1'b1, -1);
    assert (n_sync - n0 == 24) else begin
      $display("ERR %0t: gated frames gave %0d pixels, expected 24", $time, n_sync - n0);
      errors++;
    end
    finish_test("capture gate");

    // Rate over one full window of steady frames
    err0 = errors;
    fork
      repeat (RATE_FRAMES) send_frame(1'b1, -1);
      begin
        wait_toggle(t_first);
        wait_toggle(t_second);
        assert (t_second - t_first == RATE_WIN * CLK_PERIOD) else begin
          $display("ERR %0t: LED toggle interval %0t", $time, t_second - t_first);
          errors++;
        end
        assert (rate == RATE_WIN / FRAME_CYC || rate == RATE_WIN / FRAME_CYC + 1) else begin
          $display("ERR %0t: rate %0d, expected %0d or %0d", $time, rate,
                   RATE_WIN / FRAME_CYC, RATE_WIN / FRAME_CYC + 1);
          errors++;
        end
      end
    join
    finish_test("frame rate");

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== uvispace_top.f ====
rtl/vision_pkg.sv
rtl/camera_capture.sv
rtl/bayer_to_rgb.sv
rtl/frame_sync.sv
rtl/pixel_classifier.sv
rtl/rate_meter.sv
rtl/uvispace_top.sv
test/uvispace_assertions.sv
test/tb_uvispace_top.sv

// ==== Makefile ====
# Verilator flow for the uvispace video path

VERILATOR  ?= verilator
TOP        ?= tb_uvispace_top
FILELIST   ?= uvispace_top.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall --timing --assert
SIM_FLAGS  ?= --timing --assert -Wno-fatal
PASS_TEXT  ?= TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# Build and run; pass only if the pass line is printed
sim:
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
